/* tb.f */
design/sram_geometry_pkg.sv
design/err_inj_pkg.sv
design/sram_bank.sv
design/bitflip_injector.sv
design/sram_region.sv
design/sram_export.sv
test/clk_gen.sv
test/sram_export_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SRAM subsystem testbench with Verilator

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module sram_export_tb -f tb.f -o sram_export_sim \
    && ./obj_dir/sram_export_sim | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

/* test/sram_export_tb.sv */
/*
 * SRAM subsystem testbench: write bursts and read-back of both regions,
 * checked against a shadow memory under each injection mode
 */
`default_nettype none

module sram_export_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W     = sram_geometry_pkg::WORD_WIDTH;
    localparam int NB_I  = sram_geometry_pkg::ICCM_NUM_BANKS;
    localparam int NB_D  = sram_geometry_pkg::DCCM_NUM_BANKS;
    localparam int XB_I  = sram_geometry_pkg::ICCM_INDEX_BITS;
    localparam int XB_D  = sram_geometry_pkg::DCCM_INDEX_BITS;
    localparam int NB    = (NB_I > NB_D) ? NB_I : NB_D;
    localparam int DEPTH = 2 ** ((XB_I > XB_D) ? XB_I : XB_D);
    localparam int BURST = 16;
    // Eleven bursts of accesses plus reset and a margin
    localparam int WATCHDOG_NS = (11 * BURST + 10) * 40 + 2000;

    logic                   el2_mem_export;
    logic                   arst_n;
    err_inj_pkg::inj_mode_t iccm_mode;
    err_inj_pkg::inj_mode_t dccm_mode;
    logic [NB_I-1:0]        iccm_clken;
    logic [NB_I-1:0]        iccm_wren;
    logic [NB_I*XB_I-1:0]   iccm_addr;
    logic [NB_I*W-1:0]      iccm_wdata;
    logic [NB_I*W-1:0]      iccm_rdata;
    logic [NB_D-1:0]        dccm_clken;
    logic [NB_D-1:0]        dccm_wren;
    logic [NB_D*XB_D-1:0]   dccm_addr;
    logic [NB_D*W-1:0]      dccm_wdata;
    logic [NB_D*W-1:0]      dccm_rdata;

    // Shadow memory, indexed by region (0 iccm, 1 dccm), bank and address
    logic [W-1:0]           shadow      [2][NB][DEPTH];
    err_inj_pkg::inj_mode_t shadow_mode [2][NB][DEPTH];
    logic [W-1:0]           seen        [2][NB][DEPTH];
    logic                   seen_valid  [2][NB][DEPTH];
    int                     burst_addr  [2][NB][BURST];
    int                     flip_hits   [2][NB];
    logic                   pend_rd     [2][NB];
    int                     pend_addr   [2][NB];
    int                     errors;
    int                     checks;
    logic [31:0]            rng_state;

    clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clk_gen (
        .el2_mem_export (el2_mem_export),
        .arst_n         (arst_n)
    );

    sram_export i_dut (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = rng_state[31] ^ rng_state[21] ^ rng_state[1] ^ rng_state[0];
            rng_state = {rng_state[30:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic int region_banks(int r);
        return (r == 0) ? NB_I : NB_D;
    endfunction

    function automatic string region_name(int r);
        return (r == 0) ? "iccm" : "dccm";
    endfunction

    function automatic int popcount(logic [W-1:0] v);
        int n;
        n = 0;
        for (int i = 0; i < W; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    // Bits a stored word may differ by, given its write mode
    function automatic bit dist_allowed(int d, err_inj_pkg::inj_mode_t m);
        case (m)
            err_inj_pkg::INJ_SINGLE: return (d == 0) || (d == 1);
            err_inj_pkg::INJ_DOUBLE: return (d == 0) || (d == 2);
            default:                 return d == 0;
        endcase
    endfunction

    task automatic drive_bank(int r, int b, logic en, logic wr, int a, logic [W-1:0] d);
        if (r == 0) begin
            iccm_clken[b] = en;
            iccm_wren[b] = wr;
            iccm_addr[b*XB_I +: XB_I] = XB_I'(a);
            iccm_wdata[b*W +: W] = d;
        end else begin
            dccm_clken[b] = en;
            dccm_wren[b] = wr;
            dccm_addr[b*XB_D +: XB_D] = XB_D'(a);
            dccm_wdata[b*W +: W] = d;
        end
        if (en && wr) begin
            shadow[r][b][a] = d;
            shadow_mode[r][b][a] = (r == 0) ? iccm_mode : dccm_mode;
            seen_valid[r][b][a] = 1'b0;
        end
        pend_rd[r][b] = en && !wr;
        pend_addr[r][b] = a;
    endtask

    task automatic check_reads();
        logic [W-1:0] got;
        logic [W-1:0] exp;
        int           a;
        int           d;
        for (int r = 0; r < 2; r++) begin
            for (int b = 0; b < region_banks(r); b++) begin
                if (pend_rd[r][b]) begin
                    a = pend_addr[r][b];
                    got = (r == 0) ? iccm_rdata[b*W +: W] : dccm_rdata[b*W +: W];
                    exp = shadow[r][b][a];
                    d = popcount(got ^ exp);
                    checks++;
                    assert (dist_allowed(d, shadow_mode[r][b][a])) else begin
                        errors++;
                        $display("MISMATCH %s_rdata[%0d] addr %0h: got %h expected %h",
                                 region_name(r), b, a, got, exp);
                    end
                    if (d > 0 && dist_allowed(d, shadow_mode[r][b][a])) begin
                        flip_hits[r][b]++;
                    end
                    if (seen_valid[r][b][a]) begin
                        checks++;
                        assert (got == seen[r][b][a]) else begin
                            errors++;
                            $display("MISMATCH %s_rdata[%0d] addr %0h: got %h expected %h",
                                     region_name(r), b, a, got, seen[r][b][a]);
                        end
                    end else begin
                        seen[r][b][a] = got;
                        seen_valid[r][b][a] = 1'b1;
                    end
                end
            end
        end
    endtask

    // Reads issued at the last edge are checked, then the ports go idle
    task automatic next_cycle();
        @(posedge el2_mem_export);
        #2;
        check_reads();
        for (int r = 0; r < 2; r++) begin
            for (int b = 0; b < region_banks(r); b++) begin
                drive_bank(r, b, 1'b0, 1'b0, 0, '0);
            end
        end
    endtask

    task automatic write_burst(bit same_addr);
        int base [2][NB];
        int a;
        for (int r = 0; r < 2; r++) begin
            for (int b = 0; b < region_banks(r); b++) begin
                base[r][b] = (same_addr && b > 0) ? base[r][0] : int'(take_bits(7));
            end
        end
        for (int i = 0; i < BURST; i++) begin
            for (int r = 0; r < 2; r++) begin
                for (int b = 0; b < region_banks(r); b++) begin
                    a = (base[r][b] + i) % ((r == 0) ? 2 ** XB_I : 2 ** XB_D);
                    burst_addr[r][b][i] = a;
                    drive_bank(r, b, 1'b1, 1'b1, a, W'(take_bits(W)));
                end
            end
            next_cycle();
        end
    endtask

    task automatic read_burst();
        for (int i = 0; i < BURST; i++) begin
            for (int r = 0; r < 2; r++) begin
                for (int b = 0; b < region_banks(r); b++) begin
                    drive_bank(r, b, 1'b1, 1'b0, burst_addr[r][b][i], '0);
                end
            end
            next_cycle();
        end
    endtask

    task automatic check_flip_hits(int r);
        for (int b = 0; b < region_banks(r); b++) begin
            checks++;
            assert (flip_hits[r][b] > 0) else begin
                errors++;
                $display("No corrupted word seen in %s bank %0d over %0d write cycles",
                         region_name(r), b, BURST);
            end
            flip_hits[r][b] = 0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks on every cycle
    ////////////////////////////////////////////////////////////////////////////

    rdata_hold_iccm: assert property (@(posedge el2_mem_export) disable iff (!arst_n)
        ((iccm_clken & ~iccm_wren) == '0) |=> $stable(iccm_rdata))
        else begin
            errors++;
            $display("iccm_rdata changed in a cycle with no read");
        end

    rdata_hold_dccm: assert property (@(posedge el2_mem_export) disable iff (!arst_n)
        ((dccm_clken & ~dccm_wren) == '0) |=> $stable(dccm_rdata))
        else begin
            errors++;
            $display("dccm_rdata changed in a cycle with no read");
        end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        errors = 0;
        checks = 0;
        rng_state = 32'h3b7f2f32;
        iccm_mode = err_inj_pkg::INJ_OFF;
        dccm_mode = err_inj_pkg::INJ_OFF;
        for (int r = 0; r < 2; r++) begin
            for (int b = 0; b < NB; b++) begin
                flip_hits[r][b] = 0;
                for (int a = 0; a < DEPTH; a++) begin
                    seen_valid[r][b][a] = 1'b0;
                end
                if (b < region_banks(r)) begin
                    drive_bank(r, b, 1'b0, 1'b0, 0, '0);
                end
            end
        end
        wait (arst_n === 1'b1);
        @(posedge el2_mem_export);
        #2;
        checks += 2;
        assert (iccm_rdata == '0) else begin
            errors++;
            $display("MISMATCH iccm_rdata after reset: got %h expected 0", iccm_rdata);
        end
        assert (dccm_rdata == '0) else begin
            errors++;
            $display("MISMATCH dccm_rdata after reset: got %h expected 0", dccm_rdata);
        end

        // Exact read-back, first with one shared address across banks
        write_burst(1'b1);
        read_burst();
        write_burst(1'b0);
        read_burst();

        iccm_mode = err_inj_pkg::INJ_SINGLE;
        dccm_mode = err_inj_pkg::INJ_SINGLE;
        write_burst(1'b0);
        read_burst();
        check_flip_hits(0);
        check_flip_hits(1);

        iccm_mode = err_inj_pkg::INJ_DOUBLE;
        dccm_mode = err_inj_pkg::INJ_DOUBLE;
        write_burst(1'b0);
        read_burst();
        check_flip_hits(0);
        check_flip_hits(1);

        // Regions set apart, every word read twice
        iccm_mode = err_inj_pkg::INJ_OFF;
        dccm_mode = err_inj_pkg::INJ_DOUBLE;
        write_burst(1'b0);
        read_burst();
        read_burst();
        check_flip_hits(1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* test/clk_gen.sv */
/*
 * Testbench clock and reset source, reset held for the first cycles
 */
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic el2_mem_export,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        el2_mem_export = 1'b0;
        forever #(PERIOD_NS / 2) el2_mem_export = ~el2_mem_export;
    end

    // Release lands just after an edge, same as the stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge el2_mem_export);
        #2 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* design/sram_export.sv */
/*
 * SRAM subsystem top: independent iccm and dccm regions, each with its
 * own banks and write error injector
 */
`default_nettype none

module sram_export (
    input  logic                    el2_mem_export,
    input  logic                    arst_n,
    input  err_inj_pkg::inj_mode_t  iccm_mode,
    input  err_inj_pkg::inj_mode_t  dccm_mode,

    // iccm
    input  logic [sram_geometry_pkg::ICCM_NUM_BANKS-1:0] iccm_clken,
    input  logic [sram_geometry_pkg::ICCM_NUM_BANKS-1:0] iccm_wren,
    input  logic [sram_geometry_pkg::ICCM_NUM_BANKS*sram_geometry_pkg::ICCM_INDEX_BITS-1:0]
                                                         iccm_addr,
    input  logic [sram_geometry_pkg::ICCM_NUM_BANKS*sram_geometry_pkg::WORD_WIDTH-1:0]
                                                         iccm_wdata,
    output logic [sram_geometry_pkg::ICCM_NUM_BANKS*sram_geometry_pkg::WORD_WIDTH-1:0]
                                                         iccm_rdata,

    // dccm
    input  logic [sram_geometry_pkg::DCCM_NUM_BANKS-1:0] dccm_clken,
    input  logic [sram_geometry_pkg::DCCM_NUM_BANKS-1:0] dccm_wren,
    input  logic [sram_geometry_pkg::DCCM_NUM_BANKS*sram_geometry_pkg::DCCM_INDEX_BITS-1:0]
                                                         dccm_addr,
    input  logic [sram_geometry_pkg::DCCM_NUM_BANKS*sram_geometry_pkg::WORD_WIDTH-1:0]
                                                         dccm_wdata,
    output logic [sram_geometry_pkg::DCCM_NUM_BANKS*sram_geometry_pkg::WORD_WIDTH-1:0]
                                                         dccm_rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // Instruction memory
    ////////////////////////////////////////////////////////////////////////////

    sram_region #(
        .NUM_BANKS  (sram_geometry_pkg::ICCM_NUM_BANKS),
        .INDEX_BITS (sram_geometry_pkg::ICCM_INDEX_BITS),
        .SEED       (err_inj_pkg::ICCM_SEED)
    ) u_iccm (
        .el2_mem_export (el2_mem_export),
        .arst_n         (arst_n),
        .mode           (iccm_mode),
        .clken          (iccm_clken),
        .wren           (iccm_wren),
        .addr           (iccm_addr),
        .wdata          (iccm_wdata),
        .rdata          (iccm_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////////////////////

    // Separate seed so the two regions do not corrupt in lockstep
    sram_region #(
        .NUM_BANKS  (sram_geometry_pkg::DCCM_NUM_BANKS),
        .INDEX_BITS (sram_geometry_pkg::DCCM_INDEX_BITS),
        .SEED       (err_inj_pkg::DCCM_SEED)
    ) u_dccm (
        .el2_mem_export (el2_mem_export),
        .arst_n         (arst_n),
        .mode           (dccm_mode),
        .clken          (dccm_clken),
        .wren           (dccm_wren),
        .addr           (dccm_addr),
        .wdata          (dccm_wdata),
        .rdata          (dccm_rdata)
    );

endmodule

`default_nettype wire

/* design/sram_region.sv */
/*
 * One memory region: a row of SRAM banks whose write data passes
 * through the region's error injector
 */
`default_nettype none

module sram_region #(
    parameter int                                  NUM_BANKS  = 4,
    parameter int                                  INDEX_BITS = 6,
    parameter logic [err_inj_pkg::LFSR_WIDTH-1:0]  SEED       = err_inj_pkg::ICCM_SEED
) (
    input  logic                                                el2_mem_export,
    input  logic                                                arst_n,
    input  err_inj_pkg::inj_mode_t                              mode,
    input  logic [NUM_BANKS-1:0]                                clken,
    input  logic [NUM_BANKS-1:0]                                wren,
    input  logic [NUM_BANKS*INDEX_BITS-1:0]                     addr,
    input  logic [NUM_BANKS*sram_geometry_pkg::WORD_WIDTH-1:0]  wdata,
    output logic [NUM_BANKS*sram_geometry_pkg::WORD_WIDTH-1:0]  rdata
);

    localparam int W = sram_geometry_pkg::WORD_WIDTH;

    logic [NUM_BANKS-1:0]   wr_strobe;
    logic [NUM_BANKS*W-1:0] flip_mask;
    logic [NUM_BANKS*W-1:0] bank_wdata;

    assign wr_strobe  = clken & wren;
    // Mask is all zero for banks not corrupted this cycle
    assign bank_wdata = wdata ^ flip_mask;

    bitflip_injector #(
        .NUM_BANKS (NUM_BANKS),
        .SEED      (SEED)
    ) u_injector (
        .el2_mem_export (el2_mem_export),
        .arst_n         (arst_n),
        .mode           (mode),
        .wr_strobe      (wr_strobe),
        .flip_mask      (flip_mask)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Banks
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank #(
            .INDEX_BITS (INDEX_BITS)
        ) u_bank (
            .el2_mem_export (el2_mem_export),
            .arst_n         (arst_n),
            .clken          (clken[b]),
            .wren           (wren[b]),
            .addr           (addr[b*INDEX_BITS +: INDEX_BITS]),
            .wdata          (bank_wdata[b*W +: W]),
            .rdata          (rdata[b*W +: W])
        );
    end

endmodule

`default_nettype wire

/* design/bitflip_injector.sv */
/*
 * LFSR-driven write data corruption for one memory region, producing a
 * per-bank flip mask with zero, one or two bits set
 */
`default_nettype none

module bitflip_injector #(
    parameter int                                     NUM_BANKS = 4,
    parameter logic [err_inj_pkg::LFSR_WIDTH-1:0]     SEED      = err_inj_pkg::ICCM_SEED
) (
    input  logic                                                el2_mem_export,
    input  logic                                                arst_n,
    input  err_inj_pkg::inj_mode_t                              mode,
    input  logic [NUM_BANKS-1:0]                                wr_strobe,
    output logic [NUM_BANKS*sram_geometry_pkg::WORD_WIDTH-1:0]  flip_mask
);

    localparam int W  = sram_geometry_pkg::WORD_WIDTH;
    localparam int LW = err_inj_pkg::LFSR_WIDTH;

    logic [LW-1:0]   lfsr;
    logic            feedback;
    logic [2*LW-1:0] lfsr_dbl;
    logic            inj_en;
    logic            inj_double;

    ////////////////////////////////////////////////////////////////////////////
    // Fibonacci LFSR, one step per write cycle of the region
    ////////////////////////////////////////////////////////////////////////////

    assign feedback = ^(lfsr & err_inj_pkg::LFSR_TAPS);

    always_ff @(posedge el2_mem_export or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= SEED;
        end else if (|wr_strobe) begin
            lfsr <= {lfsr[LW-2:0], feedback};
        end
    end

    assign inj_en     = (mode == err_inj_pkg::INJ_SINGLE) || (mode == err_inj_pkg::INJ_DOUBLE);
    assign inj_double = (mode == err_inj_pkg::INJ_DOUBLE);
    assign lfsr_dbl   = {lfsr, lfsr};

    ////////////////////////////////////////////////////////////////////////////
    // Per-bank masks
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        // Each bank looks at a rotated copy so positions differ between banks
        localparam int ROT = (4 * b) % LW;

        logic [LW-1:0] rot;
        logic [5:0]    pos_a;
        logic [5:0]    off_b;
        logic [6:0]    sum_b;
        logic [5:0]    pos_b;
        logic [W-1:0]  mask;

        assign rot = lfsr_dbl[ROT +: LW];

        always_comb begin
            pos_a = (rot[5:0] ^ {2'b00, rot[15:12]}) % 6'd39;
            // Offset of 1..38 keeps the second position distinct
            off_b = 6'd1 + (rot[11:6] % 6'd38);
            sum_b = {1'b0, pos_a} + {1'b0, off_b};
            pos_b = 6'(sum_b % 7'd39);

            mask = '0;
            if (inj_en && lfsr[b]) begin
                mask[pos_a] = 1'b1;
                if (inj_double) begin
                    mask[pos_b] = 1'b1;
                end
            end
        end

        assign flip_mask[b*W +: W] = mask;
    end

endmodule

`default_nettype wire

/* design/sram_bank.sv */
/*
 * Single-port synchronous SRAM bank with a registered read port
 */
`default_nettype none

module sram_bank #(
    parameter int INDEX_BITS = 6
) (
    input  logic                                      el2_mem_export,
    input  logic                                      arst_n,
    input  logic                                      clken,
    input  logic                                      wren,
    input  logic [INDEX_BITS-1:0]                     addr,
    input  logic [sram_geometry_pkg::WORD_WIDTH-1:0]  wdata,
    output logic [sram_geometry_pkg::WORD_WIDTH-1:0]  rdata
);

    localparam int DEPTH = 2 ** INDEX_BITS;

    logic [sram_geometry_pkg::WORD_WIDTH-1:0] mem [DEPTH];

    // Storage array, contents undefined until written
    always_ff @(posedge el2_mem_export) begin
        if (clken && wren) begin
            mem[addr] <= wdata;
        end
    end

    // Read data holds between reads, writes leave it alone
    always_ff @(posedge el2_mem_export or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (clken && !wren) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* design/err_inj_pkg.sv */
/*
 * Error injection definitions: mode encoding and the LFSR that drives
 * bit flip decisions in each memory region
 */
`default_nettype none

package err_inj_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Injection mode
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        INJ_OFF    = 2'd0,
        INJ_SINGLE = 2'd1,
        INJ_DOUBLE = 2'd2
    } inj_mode_t;

    ////////////////////////////////////////////////////////////////////////////
    // LFSR
    ////////////////////////////////////////////////////////////////////////////

    localparam int LFSR_WIDTH = 16;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hB400;

    // Must be nonzero, the all-zero state locks up
    localparam logic [LFSR_WIDTH-1:0] ICCM_SEED = 16'hACE1;
    localparam logic [LFSR_WIDTH-1:0] DCCM_SEED = 16'h1D35;

endpackage

`default_nettype wire

/* design/sram_geometry_pkg.sv */
/*
 * SRAM geometry: stored word width and default bank layout of the
 * instruction (iccm) and data (dccm) memory regions
 */
`default_nettype none

package sram_geometry_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Word format
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_BITS  = 32;
    localparam int ECC_BITS   = 7;
    // Data plus check bits, as stored in a bank
    localparam int WORD_WIDTH = DATA_BITS + ECC_BITS;

    ////////////////////////////////////////////////////////////////////////////
    // Region defaults
    ////////////////////////////////////////////////////////////////////////////

    localparam int ICCM_NUM_BANKS  = 4;
    localparam int DCCM_NUM_BANKS  = 4;

    // Address bits per bank, depth is 2**INDEX_BITS
    localparam int ICCM_INDEX_BITS = 6;
    localparam int DCCM_INDEX_BITS = 7;

endpackage

`default_nettype wire
